// ==== verilog/cpuPkg.sv ====
// shared sizes, vector types, opcode and condition encodings, and bus structs of the core
package cpuPkg;

	// memory, register file and queue sizes
	localparam int imemDepth = 256;
	localparam int dmemDepth = 256;
	localparam int regCount = 16;
	localparam int queueDepth = 2;
	localparam int imemAddrWidth = $clog2(imemDepth);
	localparam int dmemAddrWidth = $clog2(dmemDepth);
	localparam int queuePtrWidth = $clog2(queueDepth);
	localparam int queueCountWidth = $clog2(queueDepth + 1);

	// data, address and instruction value
	typedef logic [15:0] word;
	typedef logic [3:0] regIndex;
	typedef logic [2:0] condCode;
	typedef logic [imemAddrWidth-1:0] imemAddress;
	typedef logic [dmemAddrWidth-1:0] dmemAddress;
	typedef logic [queuePtrWidth-1:0] queuePtr;
	typedef logic [queueCountWidth-1:0] queueCount;

	// top nibble of the instruction
	typedef enum logic [3:0] {
		opAdd = 4'd0, opSub, opRed, opXor, opSll, opSra, opRor, opPaddsb,
		opLw, opSw, opLhb, opLlb, opB, opBr, opPcs, opHlt
	} opcode;

	// branch conditions, bits 11:9 of B and BR
	localparam condCode condNe = 3'd0;
	localparam condCode condEq = 3'd1;
	localparam condCode condGt = 3'd2;
	localparam condCode condLt = 3'd3;
	localparam condCode condGe = 3'd4;
	localparam condCode condLe = 3'd5;
	localparam condCode condOv = 3'd6;
	localparam condCode condAlways = 3'd7;

	typedef struct packed {
		logic zero;
		logic overflow;
		logic negative;
	} flagSet;

	// decoder outputs
	typedef struct packed {
		logic regSrc;
		logic regWrite;
		logic ldByte;
		logic memOp;
		logic memWrite;
		logic branchSrc;
		logic branch;
		logic dataSrc;
		logic hlt;
		logic setsAllFlags;
		logic setsZeroFlag;
	} controlWord;

	typedef struct packed {
		word pc;
		word instruction;
	} fetchEntry;

	typedef struct packed {
		word pc;
		logic writeEnable;
		regIndex writeReg;
		word writeData;
	} retireInfo;

endpackage

// ==== verilog/control.sv ====
// opcode decoder producing the control word and flag-update class
module control import cpuPkg::*; (
	input  opcode      op,
	output controlWord controls
);

	always_comb begin
		controls = '0;
		case (op)
			// arithmetic sets zero, overflow and negative
			opAdd, opSub: begin
				controls.regWrite = 1'b1;
				controls.setsAllFlags = 1'b1;
			end
			// logic and shifts touch zero only
			opXor, opSll, opSra, opRor: begin
				controls.regWrite = 1'b1;
				controls.setsZeroFlag = 1'b1;
			end
			// not implemented, decoded as no-ops
			opRed, opPaddsb: begin
				controls.regWrite = 1'b0;
			end
			// writeback from data memory
			opLw: begin
				controls.regWrite = 1'b1;
				controls.memOp = 1'b1;
				controls.dataSrc = 1'b1;
			end
			// slot 1 holds the store data register
			opSw: begin
				controls.regSrc = 1'b1;
				controls.memOp = 1'b1;
				controls.memWrite = 1'b1;
			end
			// byte loads read their own destination for the merge
			opLhb, opLlb: begin
				controls.regSrc = 1'b1;
				controls.regWrite = 1'b1;
				controls.ldByte = 1'b1;
			end
			opB: begin
				controls.branch = 1'b1;
			end
			// target from rs
			opBr: begin
				controls.branch = 1'b1;
				controls.branchSrc = 1'b1;
			end
			opPcs: begin
				controls.regWrite = 1'b1;
			end
			opHlt: begin
				controls.hlt = 1'b1;
			end
			default: begin
				controls = '0;
			end
		endcase
	end

endmodule

// ==== verilog/registerFile.sv ====
// sixteen-entry register file, two bypassed read ports, one write port, r0 tied to zero
module registerFile import cpuPkg::*; (
	input  logic    clk,
	input  logic    reset,
	input  regIndex readReg1,
	input  regIndex readReg2,
	input  regIndex writeReg,
	input  logic    writeEnable,
	input  word     writeData,
	output word     readData1,
	output word     readData2
);

	word regs [regCount];

	// r0 is never written
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < regCount; i++) begin
				regs[i] <= '0;
			end
		end else if (writeEnable && (writeReg != '0)) begin
			regs[writeReg] <= writeData;
		end
	end

	// write in this cycle is seen by readers in this cycle
	assign readData1 = (readReg1 == '0) ? '0 :
		(writeEnable && (writeReg == readReg1)) ? writeData : regs[readReg1];
	assign readData2 = (readReg2 == '0) ? '0 :
		(writeEnable && (writeReg == readReg2)) ? writeData : regs[readReg2];

endmodule

// ==== verilog/instructionFetch.sv ====
// program counter, redirect and halt handling, instruction memory with its load port
module instructionFetch import cpuPkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  logic       imemLoad,
	input  imemAddress imemLoadAddress,
	input  word        imemLoadData,
	input  logic       almostFull,
	input  logic       redirect,
	input  word        redirectPc,
	input  logic       haltRequest,
	output logic       fetchValid,
	output fetchEntry  fetchData
);

	word pc;
	word readPc;
	word readData;
	logic inFlight;
	logic stale;
	logic stopped;
	logic issue;

	// program words, indexed by pc without its byte bit
	word imem [imemDepth];

	// a new read only when the queue can still take its data
	assign issue = !stopped && !almostFull;

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= '0;
			inFlight <= 1'b0;
			stale <= 1'b0;
			stopped <= 1'b0;
		end else begin
			inFlight <= issue;
			// read launched in the redirect cycle is on the old path
			stale <= redirect;
			// halt is sticky until reset
			if (haltRequest) begin
				stopped <= 1'b1;
			end
			if (redirect) begin
				pc <= redirectPc;
			end else if (issue) begin
				pc <= pc + 16'd2;
			end
		end
	end

	// synchronous read, load port writes while the core is held in reset
	always_ff @(posedge clk) begin
		if (imemLoad) begin
			imem[imemLoadAddress] <= imemLoadData;
		end
		if (issue) begin
			readData <= imem[pc[imemAddrWidth:1]];
			readPc <= pc;
		end
	end

	// data returns one cycle after the read
	assign fetchValid = inFlight && !stale;
	assign fetchData = '{pc: readPc, instruction: readData};

endmodule

// ==== verilog/fetchQueue.sv ====
// two-entry circular instruction queue with flush and almost-full level
module fetchQueue import cpuPkg::*; (
	input  logic      clk,
	input  logic      reset,
	input  logic      fetchValid,
	input  fetchEntry fetchData,
	input  logic      take,
	input  logic      redirect,
	output logic      almostFull,
	output logic      headValid,
	output fetchEntry headEntry
);

	fetchEntry entries [queueDepth];
	queuePtr readPtr;
	queuePtr writePtr;
	queueCount count;
	logic push;
	logic pop;

	// pointer step with wrap at the last slot
	function automatic queuePtr nextPtr(input queuePtr ptr);
		return (ptr == queuePtr'(queueDepth - 1)) ? '0 : ptr + 1'b1;
	endfunction

	// data arriving with a redirect belongs to the old path
	assign push = fetchValid && !redirect;
	assign pop = take && headValid;

	always_ff @(posedge clk) begin
		if (reset || redirect) begin
			readPtr <= '0;
			writePtr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				writePtr <= nextPtr(writePtr);
			end
			if (pop) begin
				readPtr <= nextPtr(readPtr);
			end
			count <= count + queueCount'(push) - queueCount'(pop);
		end
	end

	always_ff @(posedge clk) begin
		if (push) begin
			entries[writePtr] <= fetchData;
		end
	end

	assign headValid = (count != '0);
	assign headEntry = entries[readPtr];

	// keep one slot for the read that may already be in flight
	assign almostFull = (count == queueCount'(queueDepth)) ||
		((count == queueCount'(1)) && !take);

endmodule

// ==== verilog/executeUnit.sv ====
// decode, ALU, flags, branch resolution, data memory, writeback and retire reporting
module executeUnit import cpuPkg::*; (
	input  logic      clk,
	input  logic      reset,
	input  logic      headValid,
	input  fetchEntry headEntry,
	output logic      take,
	output logic      redirect,
	output word       redirectPc,
	output logic      haltRequest,
	output logic      retire,
	output retireInfo retireData,
	output logic      store,
	output word       storeAddress,
	output word       storeData,
	output logic      halted
);

	typedef enum logic {idle, loadWait} executeState;

	executeState state;
	word instr;
	word pc;
	word pcPlus2;
	opcode op;
	controlWord controls;
	regIndex rd;
	regIndex rs;
	regIndex rt;
	condCode cond;
	word rsData;
	word rtData;
	logic wbEnable;
	regIndex wbReg;
	word wbData;
	flagSet flags;
	flagSet aluFlags;
	word sum;
	word diff;
	word aluResult;
	word byteMerge;
	word resultData;
	word memAddress;
	dmemAddress memIndex;
	word loadData;
	logic condTrue;
	logic active;
	logic isLoad;
	logic finish;

	// data memory starts cleared
	word dmem [dmemDepth] = '{default: '0};

	// instruction slots
	assign instr = headEntry.instruction;
	assign pc = headEntry.pc;
	assign pcPlus2 = pc + 16'd2;
	assign op = opcode'(instr[15:12]);
	assign rd = instr[11:8];
	assign rs = instr[7:4];
	assign rt = instr[3:0];
	assign cond = instr[11:9];

	control decoder (
		.op(op),
		.controls(controls)
	);

	// second read port takes slot 1 for SW, LHB and LLB
	// writes are applied a cycle late from the writeback register
	registerFile regFile (
		.clk(clk),
		.reset(reset),
		.readReg1(rs),
		.readReg2(controls.regSrc ? rd : rt),
		.writeReg(wbReg),
		.writeEnable(wbEnable),
		.writeData(wbData),
		.readData1(rsData),
		.readData2(rtData)
	);

	assign sum = rsData + rtData;
	assign diff = rsData - rtData;

	// shifts take their amount from slot 3
	always_comb begin
		case (op)
			opAdd: aluResult = sum;
			opSub: aluResult = diff;
			opXor: aluResult = rsData ^ rtData;
			opSll: aluResult = rsData << rt;
			opSra: aluResult = word'($signed(rsData) >>> rt);
			opRor: aluResult = (rsData >> rt) | (rsData << (5'd16 - {1'b0, rt}));
			opPcs: aluResult = pcPlus2;
			default: aluResult = '0;
		endcase
	end

	// wrapping overflow from operand and result signs
	assign aluFlags.zero = (aluResult == '0);
	assign aluFlags.negative = aluResult[15];
	assign aluFlags.overflow = (op == opSub) ?
		((rsData[15] != rtData[15]) && (diff[15] != rsData[15])) :
		((rsData[15] == rtData[15]) && (sum[15] != rsData[15]));

	// LHB replaces the high byte, LLB the low byte
	assign byteMerge = (op == opLhb) ? {instr[7:0], rtData[7:0]} : {rtData[15:8], instr[7:0]};
	assign resultData = controls.dataSrc ? loadData :
		controls.ldByte ? byteMerge : aluResult;

	// conditions against flags already committed
	always_comb begin
		case (cond)
			condNe: condTrue = !flags.zero;
			condEq: condTrue = flags.zero;
			condGt: condTrue = !flags.zero && !flags.negative;
			condLt: condTrue = flags.negative;
			condGe: condTrue = flags.zero || !flags.negative;
			condLe: condTrue = flags.zero || flags.negative;
			condOv: condTrue = flags.overflow;
			condAlways: condTrue = 1'b1;
			default: condTrue = 1'b1;
		endcase
	end

	// word address from rs plus the scaled signed offset
	assign memAddress = {rsData[15:1], 1'b0} + {{11{instr[3]}}, instr[3:0], 1'b0};
	assign memIndex = memAddress[dmemAddrWidth:1];

	// LW holds the head for its read cycle
	assign active = headValid && !halted;
	assign isLoad = controls.memOp && !controls.memWrite;
	assign finish = active && (!isLoad || (state == loadWait));

	assign take = finish;
	assign retire = finish;
	assign retireData = '{pc: pc, writeEnable: controls.regWrite, writeReg: rd,
		writeData: resultData};
	assign store = finish && controls.memOp && controls.memWrite;
	assign storeAddress = memAddress;
	assign storeData = rtData;
	assign haltRequest = finish && controls.hlt;

	// B jumps relative to pc+2, BR to rs
	assign redirect = finish && controls.branch && condTrue;
	assign redirectPc = controls.branchSrc ? rsData :
		pcPlus2 + {{6{instr[8]}}, instr[8:0], 1'b0};

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= idle;
			halted <= 1'b0;
			flags <= '0;
			wbEnable <= 1'b0;
		end else begin
			wbEnable <= finish && controls.regWrite;
			if (haltRequest) begin
				halted <= 1'b1;
			end
			// flag class from the decoder
			if (finish && controls.setsAllFlags) begin
				flags <= aluFlags;
			end else if (finish && controls.setsZeroFlag) begin
				flags.zero <= aluFlags.zero;
			end
			case (state)
				idle: state <= (active && isLoad) ? loadWait : idle;
				loadWait: state <= idle;
				default: state <= idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		wbReg <= rd;
		wbData <= resultData;
	end

	// store on retire, load read in the stall cycle
	always_ff @(posedge clk) begin
		if (store) begin
			dmem[memIndex] <= rtData;
		end
		if (active && isLoad && (state == idle)) begin
			loadData <= dmem[memIndex];
		end
	end

endmodule

// ==== verilog/cpuCore.sv ====
// core top level wiring fetch, instruction queue and execute
module cpuCore import cpuPkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  logic       imemLoad,
	input  imemAddress imemLoadAddress,
	input  word        imemLoadData,
	output logic       retire,
	output retireInfo  retireData,
	output logic       store,
	output word        storeAddress,
	output word        storeData,
	output logic       halted
);

	// fetch to queue
	logic fetchValid;
	fetchEntry fetchData;
	logic almostFull;

	// queue to execute
	logic headValid;
	fetchEntry headEntry;
	logic take;

	// execute back to fetch and queue
	logic redirect;
	word redirectPc;
	logic haltRequest;

	instructionFetch fetch (
		.clk(clk),
		.reset(reset),
		.imemLoad(imemLoad),
		.imemLoadAddress(imemLoadAddress),
		.imemLoadData(imemLoadData),
		.almostFull(almostFull),
		.redirect(redirect),
		.redirectPc(redirectPc),
		.haltRequest(haltRequest),
		.fetchValid(fetchValid),
		.fetchData(fetchData)
	);

	fetchQueue queue (
		.clk(clk),
		.reset(reset),
		.fetchValid(fetchValid),
		.fetchData(fetchData),
		.take(take),
		.redirect(redirect),
		.almostFull(almostFull),
		.headValid(headValid),
		.headEntry(headEntry)
	);

	executeUnit execute (
		.clk(clk),
		.reset(reset),
		.headValid(headValid),
		.headEntry(headEntry),
		.take(take),
		.redirect(redirect),
		.redirectPc(redirectPc),
		.haltRequest(haltRequest),
		.retire(retire),
		.retireData(retireData),
		.store(store),
		.storeAddress(storeAddress),
		.storeData(storeData),
		.halted(halted)
	);

endmodule

// ==== testbench/cpuCore_properties.sv ====
// concurrent checks on queue occupancy, take, halted and strobes while halted
module cpuCore_properties import cpuPkg::*; (
	input logic      clk,
	input logic      reset,
	input queueCount count,
	input logic      headValid,
	input logic      take,
	input logic      halted,
	input logic      retire,
	input logic      redirect
);
	timeunit 1ns;
	timeprecision 1ps;

	// queue never holds more than its slots
	assert property (@(posedge clk) disable iff (reset) count <= queueCount'(queueDepth))
		else $error("queue count above depth");

	assert property (@(posedge clk) disable iff (reset) take |-> headValid)
		else $error("take without a valid head");

	// halted only clears through reset
	assert property (@(posedge clk) $fell(halted) |-> $past(reset))
		else $error("halted fell without reset");

	assert property (@(posedge clk) disable iff (reset) halted |-> !retire && !redirect)
		else $error("retire or redirect while halted");

endmodule

// ==== testbench/cpuCoreTb.sv ====
// cpuCore testbench with clock, reset, loader, ISA reference model, directed tests and checks
module cpuCoreTb import cpuPkg::*; ();
	timeunit 1ns;
	timeprecision 1ps;

	logic clk = 1'b0;
	logic reset;
	logic imemLoad;
	imemAddress imemLoadAddress;
	word imemLoadData;
	logic retire;
	retireInfo retireData;
	logic store;
	word storeAddress;
	word storeData;
	logic halted;

	// reference model state
	// data memory survives between tests like the DUT's
	word mRegs [regCount];
	logic mZero, mOver, mNeg;
	word mDmem [dmemDepth];
	word prog [$];
	retireInfo expRetire [$];
	word expStoreAddress [$];
	word expStoreData [$];
	int cycles = 0;
	int cycleLimit = 0;

	cpuCore dut_i (
		.clk(clk), .reset(reset), .imemLoad(imemLoad), .imemLoadAddress(imemLoadAddress),
		.imemLoadData(imemLoadData), .retire(retire), .retireData(retireData), .store(store),
		.storeAddress(storeAddress), .storeData(storeData), .halted(halted)
	);

	bind fetchQueue cpuCore_properties queueChecks (.clk(clk), .reset(reset), .count(count),
		.headValid(headValid), .take(take), .halted(1'b0), .retire(1'b0), .redirect(1'b0));
	bind executeUnit cpuCore_properties executeChecks (.clk(clk), .reset(reset), .count('0),
		.headValid(headValid), .take(take), .halted(halted), .retire(retire),
		.redirect(redirect));

	always #4 clk = ~clk;

	task automatic failRun(input string why);
		$display("%s", why);
		$display("sim failed");
		$fatal(1, "run stopped");
	endtask

	// limit is ten cycles for every instruction loaded so far
	always @(posedge clk) begin
		if (!reset) begin
			cycles++;
		end
		if (cycles > cycleLimit) begin
			failRun($sformatf("timeout after %0d cycles with no finished test", cycles));
		end
	end

	task automatic valueError(input string name, input word expected, input word got);
		$display("[ERROR] %0t %s expected %h got %h", $time, name, expected, got);
		failRun("value mismatch");
	endtask

	task automatic compareRetire(input retireInfo expected);
		if (retireData.pc !== expected.pc) begin
			valueError("retireData.pc", expected.pc, retireData.pc);
		end else if (retireData.writeEnable !== expected.writeEnable) begin
			valueError("retireData.writeEnable", word'(expected.writeEnable),
				word'(retireData.writeEnable));
		end else if (expected.writeEnable && (retireData.writeReg !== expected.writeReg)) begin
			valueError("retireData.writeReg", word'(expected.writeReg), word'(retireData.writeReg));
		end else if (expected.writeEnable && (retireData.writeData !== expected.writeData)) begin
			valueError("retireData.writeData", expected.writeData, retireData.writeData);
		end
	endtask

	task automatic compareStore(input word expAddress, input word expData);
		if (storeAddress !== expAddress) begin
			valueError("storeAddress", expAddress, storeAddress);
		end else if (storeData !== expData) begin
			valueError("storeData", expData, storeData);
		end
	endtask

	task automatic compareHalted(input bit expected);
		if (halted !== expected) begin
			valueError("halted", word'(expected), word'(halted));
		end
	endtask

	// instruction encoders
	function automatic word rInstr(input opcode op, input regIndex rd, input regIndex rs,
		input regIndex rt);
		return {op, rd, rs, rt};
	endfunction

	function automatic word iInstr(input opcode op, input regIndex rd, input logic [7:0] imm);
		return {op, rd, imm};
	endfunction

	function automatic word bInstr(input condCode cond, input logic [8:0] offset);
		return {opB, cond, offset};
	endfunction

	function automatic logic condHolds(input condCode cond);
		case (cond)
			3'd0: return !mZero;
			3'd1: return mZero;
			3'd2: return !mZero && !mNeg;
			3'd3: return mNeg;
			3'd4: return mZero || !mNeg;
			3'd5: return mZero || mNeg;
			3'd6: return mOver;
			default: return 1'b1;
		endcase
	endfunction

	// steps the loaded program by the ISA rules up to HLT
	task automatic predictProgram();
		word pc, ins, a, b, res, addr, target;
		opcode op;
		logic [3:0] sh;
		retireInfo r;
		logic taken, done;
		int steps;
		pc = '0;
		done = 1'b0;
		steps = 0;
		for (int i = 0; i < regCount; i++) begin
			mRegs[i] = '0;
		end
		{mZero, mOver, mNeg} = 3'b000;
		expRetire.delete();
		expStoreAddress.delete();
		expStoreData.delete();
		while (!done && steps < 200) begin
			ins = prog[pc >> 1];
			op = opcode'(ins[15:12]);
			a = mRegs[ins[7:4]];
			b = mRegs[ins[3:0]];
			sh = ins[3:0];
			addr = {a[15:1], 1'b0} + {{11{ins[3]}}, ins[3:0], 1'b0};
			r = '{pc: pc, writeEnable: 1'b1, writeReg: ins[11:8], writeData: '0};
			taken = 1'b0;
			target = '0;
			res = '0;
			case (op)
				opAdd: begin
					res = a + b;
					mOver = (a[15] == b[15]) && (res[15] != a[15]);
				end
				opSub: begin
					res = a - b;
					mOver = (a[15] != b[15]) && (res[15] != a[15]);
				end
				opXor: res = a ^ b;
				opSll: res = a << sh;
				opSra: res = word'($signed(a) >>> sh);
				opRor: res = word'({a, a} >> sh);
				opLw: res = mDmem[addr[dmemAddrWidth:1]];
				opLhb: res = {ins[7:0], mRegs[ins[11:8]][7:0]};
				opLlb: res = {mRegs[ins[11:8]][15:8], ins[7:0]};
				opPcs: res = pc + 16'd2;
				default: r.writeEnable = 1'b0;
			endcase
			// flags by class
			if (op inside {opAdd, opSub}) begin
				mNeg = res[15];
			end
			if (op inside {opAdd, opSub, opXor, opSll, opSra, opRor}) begin
				mZero = (res == '0);
			end
			if (op == opSw) begin
				expStoreAddress.push_back(addr);
				expStoreData.push_back(mRegs[ins[11:8]]);
				mDmem[addr[dmemAddrWidth:1]] = mRegs[ins[11:8]];
			end
			if (op == opB || op == opBr) begin
				taken = condHolds(ins[11:9]);
				target = (op == opBr) ? a : pc + 16'd2 + {{6{ins[8]}}, ins[8:0], 1'b0};
			end
			done = (op == opHlt);
			r.writeData = res;
			if (r.writeEnable && ins[11:8] != 4'd0) begin
				mRegs[ins[11:8]] = res;
			end
			expRetire.push_back(r);
			pc = taken ? target : pc + 16'd2;
			steps++;
		end
	endtask

	// holds reset, writes the program, then releases the core
	task automatic loadProgram();
		reset = 1'b1;
		imemLoad = 1'b0;
		repeat (5) @(negedge clk);
		foreach (prog[i]) begin
			imemLoad = 1'b1;
			imemLoadAddress = imemAddress'(i);
			imemLoadData = prog[i];
			@(negedge clk);
		end
		imemLoad = 1'b0;
		cycleLimit = cycleLimit + 10 * prog.size();
		predictProgram();
		reset = 1'b0;
	endtask

	// follows retire and store strobes against the model, then watches the halt
	task automatic runProgram();
		int ridx;
		bit finished;
		ridx = 0;
		finished = 1'b0;
		while (!finished) begin
			@(negedge clk);
			compareHalted(1'b0);
			if (store && expStoreAddress.size() == 0) begin
				failRun("store strobe where the model has no store");
			end else if (store) begin
				compareStore(expStoreAddress.pop_front(), expStoreData.pop_front());
			end
			if (retire) begin
				compareRetire(expRetire[ridx]);
				ridx++;
				finished = (ridx == expRetire.size());
			end
		end
		if (expStoreAddress.size() != 0) begin
			failRun("a modeled store never appeared");
		end
		repeat (20) begin
			@(negedge clk);
			compareHalted(1'b1);
			if (retire || store) begin
				failRun("retire or store after halt");
			end
		end
	endtask

	task automatic testAlu();
		prog.delete();
		prog = {iInstr(opLlb, 1, 8'h34), iInstr(opLhb, 1, 8'h12), iInstr(opLlb, 2, 8'h03),
			iInstr(opLhb, 2, 8'h00), rInstr(opAdd, 3, 1, 2), rInstr(opSub, 4, 1, 2),
			rInstr(opXor, 5, 1, 2), rInstr(opSll, 6, 1, 4), iInstr(opLlb, 8, 8'h80),
			iInstr(opLhb, 8, 8'h80), rInstr(opSra, 7, 8, 3), rInstr(opRor, 9, 1, 4),
			rInstr(opAdd, 0, 1, 2), rInstr(opAdd, 10, 0, 1), 16'hF000};
		loadProgram();
		runProgram();
	endtask

	// loads right after stores, dependent use right after a load
	task automatic testMemory();
		prog.delete();
		prog = {iInstr(opLlb, 1, 8'h20), iInstr(opLlb, 2, 8'hAB), iInstr(opLhb, 2, 8'hCD),
			rInstr(opSw, 2, 1, 2), rInstr(opLw, 3, 1, 2), rInstr(opAdd, 4, 3, 3),
			rInstr(opLw, 5, 1, 4'hF), rInstr(opSub, 6, 5, 3), rInstr(opSw, 4, 1, 4'hE),
			rInstr(opLw, 7, 1, 4'hE), 16'hF000};
		loadProgram();
		runProgram();
	endtask

	// all eight conditions under positive, negative, zero and overflow flags
	task automatic testBranches();
		int k;
		prog.delete();
		prog = {iInstr(opLlb, 1, 8'd5), iInstr(opLlb, 2, 8'd3)};
		for (int s = 0; s < 4; s++) begin
			if (s == 0) begin
				prog.push_back(rInstr(opSub, 3, 1, 2));
			end else if (s == 1) begin
				prog.push_back(rInstr(opSub, 3, 2, 1));
			end else if (s == 2) begin
				prog.push_back(rInstr(opXor, 8, 1, 1));
			end else begin
				prog.push_back(iInstr(opLlb, 4, 8'hFF));
				prog.push_back(iInstr(opLhb, 4, 8'h7F));
				prog.push_back(rInstr(opAdd, 5, 4, 4));
			end
			for (int c = 0; c < 8; c++) begin
				prog.push_back(bInstr(condCode'(c), 9'd1));
				prog.push_back(iInstr(opLlb, 10, 8'(16 * s + c)));
			end
		end
		// BR jumps over one word onto HLT
		k = prog.size();
		prog.push_back({opPcs, 4'd6, 8'd0});
		prog.push_back(iInstr(opLlb, 7, 8'(2 * (k + 4))));
		prog.push_back({opBr, 3'd7, 1'b0, 4'd7, 4'd0});
		prog.push_back(iInstr(opLlb, 9, 8'hEE));
		prog.push_back(16'hF000);
		loadProgram();
		runProgram();
	endtask

	// RED and PADDSB keep flags, words past HLT never run
	task automatic testExcluded();
		prog.delete();
		prog = {iInstr(opLlb, 1, 8'd1), iInstr(opLlb, 2, 8'd2), rInstr(opSub, 3, 1, 2),
			rInstr(opRed, 4, 1, 2), rInstr(opPaddsb, 5, 1, 2), bInstr(3'd1, 9'd1),
			iInstr(opLlb, 9, 8'hEE), iInstr(opLlb, 11, 8'h55), rInstr(opPaddsb, 5, 1, 2),
			bInstr(3'd0, 9'd1), iInstr(opLlb, 12, 8'h66), 16'hF000,
			iInstr(opLlb, 13, 8'h77), rInstr(opSw, 13, 0, 0)};
		loadProgram();
		runProgram();
	endtask

	initial begin
		reset = 1'b1;
		imemLoad = 1'b0;
		imemLoadAddress = '0;
		imemLoadData = '0;
		for (int i = 0; i < dmemDepth; i++) begin
			mDmem[i] = '0;
		end
		testAlu();
		testMemory();
		testBranches();
		testExcluded();
		$display("sim passed");
		$finish;
	end

endmodule

// ==== compile.f ====
verilog/cpuPkg.sv
verilog/control.sv
verilog/registerFile.sv
verilog/instructionFetch.sv
verilog/fetchQueue.sv
verilog/executeUnit.sv
verilog/cpuCore.sv
testbench/cpuCore_properties.sv
testbench/cpuCoreTb.sv

// ==== Bender.yml ====
package:
  name: cpu_core

sources:
  - verilog/cpuPkg.sv
  - verilog/control.sv
  - verilog/registerFile.sv
  - verilog/instructionFetch.sv
  - verilog/fetchQueue.sv
  - verilog/executeUnit.sv
  - verilog/cpuCore.sv
  - target: test
    files:
      - testbench/cpuCore_properties.sv
      - testbench/cpuCoreTb.sv
